/* all.f */
ringPkg.sv
sharedMemory.sv
memoryWriter.sv
memoryReader.sv
memoryArbiter.sv
ringBuffer.sv
ringBufferTop.sv
ringBufferTb.sv

/* memoryArbiter.sv */
`timescale 1ns/1ps

module memoryArbiter (
	input logic clk,
	input logic rst,
	input logic [1:0] requests,
	output logic [1:0] grants,
	input ringPkg::MemRequest writerMem,
	input ringPkg::MemRequest readerMem,
	output ringPkg::MemRequest memRequest
);
	import ringPkg::*;

	logic [1:0] nextGrants;

	always_ff @(posedge clk) begin
		if (rst) begin
			grants <= '0;
		end else begin
			grants <= nextGrants;
		end
	end

	// Holder keeps the grant until it lets go, then writer first
	always_comb begin
		nextGrants = grants;
		if ((requests & grants) == '0) begin
			if (requests[0]) begin
				nextGrants = 2'b01;
			end else if (requests[1]) begin
				nextGrants = 2'b10;
			end else begin
				nextGrants = '0;
			end
		end
	end

	always_comb begin
		if (grants[0]) begin
			memRequest = writerMem;
		end else if (grants[1]) begin
			memRequest = readerMem;
		end else begin
			memRequest = '0;
		end
	end

endmodule

/* memoryReader.sv */
`timescale 1ns/1ps

module memoryReader (
	input logic clk,
	input logic rst,
	input ringPkg::ClientBus clientBus,
	output logic done,
	output logic grantRequest,
	input logic grant,
	input ringPkg::MemResponse memResponse,
	output ringPkg::MemRequest memRequest,
	output ringPkg::MemWord rdWord
);
	import ringPkg::*;

	ClientState state;
	ClientState nextState;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	// Memory data is valid once busy has dropped
	always_ff @(posedge clk) begin
		if (state == ACTION && nextState == POST_ACTION) begin
			rdWord <= memResponse.rdData;
		end
	end

	always_comb begin
		nextState = state;
		unique case (state)
			IDLE: begin
				if (clientBus.request) begin
					nextState = WAIT_ACTION;
				end
			end
			WAIT_ACTION: begin
				if (grant) begin
					nextState = PRE_ACTION;
				end
			end
			PRE_ACTION: begin
				if (memResponse.busy) begin
					nextState = ACTION;
				end
			end
			ACTION: begin
				if (!memResponse.busy) begin
					nextState = POST_ACTION;
				end
			end
			POST_ACTION: begin
				nextState = clientBus.request ? WAIT_ACTION : IDLE;
			end
			default: nextState = IDLE;
		endcase
	end

	assign grantRequest = state == WAIT_ACTION || state == PRE_ACTION || state == ACTION;
	assign done = state == POST_ACTION;

	assign memRequest.writeEnable = 1'b0;
	assign memRequest.readEnable = state == PRE_ACTION;
	assign memRequest.addr = clientBus.addr;
	assign memRequest.data = '0;

endmodule

/* memoryWriter.sv */
`timescale 1ns/1ps

module memoryWriter (
	input logic clk,
	input logic rst,
	input ringPkg::ClientBus clientBus,
	output logic done,
	output logic grantRequest,
	input logic grant,
	input ringPkg::MemResponse memResponse,
	output ringPkg::MemRequest memRequest
);
	import ringPkg::*;

	ClientState state;
	ClientState nextState;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		unique case (state)
			IDLE: begin
				if (clientBus.request) begin
					nextState = WAIT_ACTION;
				end
			end
			WAIT_ACTION: begin
				if (grant) begin
					nextState = PRE_ACTION;
				end
			end
			PRE_ACTION: begin
				if (memResponse.busy) begin
					nextState = ACTION;
				end
			end
			ACTION: begin
				if (!memResponse.busy) begin
					nextState = POST_ACTION;
				end
			end
			POST_ACTION: begin
				nextState = clientBus.request ? WAIT_ACTION : IDLE;
			end
			default: nextState = IDLE;
		endcase
	end

	assign grantRequest = state == WAIT_ACTION || state == PRE_ACTION || state == ACTION;
	assign done = state == POST_ACTION;

	assign memRequest.writeEnable = state == PRE_ACTION;
	assign memRequest.readEnable = 1'b0;
	assign memRequest.addr = clientBus.addr;
	assign memRequest.data = clientBus.data;

endmodule

/* ringBuffer.sv */
`timescale 1ns/1ps

module ringBuffer (
	input logic clk,
	input logic rst,
	input ringPkg::RingControl control,
	input logic pushRequest,
	input ringPkg::MemWord pushData,
	output logic pushDone,
	input logic popRequest,
	output logic popDone,
	output logic [ringPkg::CountWidth-1:0] memUsed,
	output ringPkg::ClientBus writeBus,
	input logic writeDone,
	output ringPkg::ClientBus readBus,
	input logic readDone
);
	import ringPkg::*;

	MemAddr writePtr;
	MemAddr readPtr;
	MemAddr tailPtr;
	MemAddr nextWritePtr;
	MemAddr nextReadPtr;
	MemAddr nextTailPtr;
	MemAddr writeAdvanced;
	MemAddr visible;
	logic inTransaction;
	logic transactionActive;

	function automatic MemAddr advance(input MemAddr ptr);
		if (ptr == MemAddr'(RingDepth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Committed words sit between read pointer and tail
	assign visible = tailPtr - readPtr;
	assign memUsed = CountWidth'(visible);

	assign writeAdvanced = advance(writePtr);
	assign transactionActive = control.open | inTransaction;

	// Requests drop in the done cycle so a held level is not served twice
	assign writeBus = '{request: pushRequest & ~writeDone, addr: writePtr, data: pushData};
	assign readBus = '{
		request: popRequest & (visible != '0) & ~readDone,
		addr: readPtr,
		data: '0
	};
	assign pushDone = writeDone;
	assign popDone = readDone;

	always_ff @(posedge clk) begin
		if (rst) begin
			writePtr <= '0;
			readPtr <= '0;
			tailPtr <= '0;
			inTransaction <= 1'b0;
		end else begin
			writePtr <= nextWritePtr;
			readPtr <= nextReadPtr;
			tailPtr <= nextTailPtr;
			if (control.open) begin
				inTransaction <= 1'b1;
			end else if (control.commit | control.rollback) begin
				inTransaction <= 1'b0;
			end
		end
	end

	always_comb begin
		nextWritePtr = writePtr;
		nextReadPtr = readPtr;
		nextTailPtr = tailPtr;

		if (readDone && visible != '0) begin
			nextReadPtr = advance(readPtr);
		end

		if (writeDone) begin
			nextWritePtr = writeAdvanced;
			if (!transactionActive) begin
				nextTailPtr = writeAdvanced;
			end
			// Full ring, oldest word is dropped
			if (writeAdvanced == readPtr) begin
				nextReadPtr = advance(readPtr);
				if (tailPtr == readPtr) begin
					nextTailPtr = advance(readPtr);
				end
			end
		end

		if (control.rollback) begin
			nextWritePtr = nextTailPtr;
		end else if (control.commit) begin
			nextTailPtr = nextWritePtr;
		end
	end

endmodule

/* ringBufferTb.sv */
`timescale 1ns/1ps

module ringBufferTb;
	import ringPkg::*;

	typedef enum logic [2:0] {
		OpPush,
		OpPop,
		OpOpen,
		OpCommit,
		OpRollback,
		OpCheckUsed,
		OpPopEmpty,
		OpPushPop
	} TestOp;

	typedef struct packed {
		TestOp op;
		MemWord data;
	} Entry;

	localparam int NumEntries = 57;
	localparam int CycleLimit = NumEntries * 20;
	localparam int EmptyWait = 12;

	logic clk;
	logic rst;
	RingControl control;
	logic pushRequest;
	MemWord pushData;
	logic pushDone;
	logic popRequest;
	MemWord popData;
	logic popDone;
	logic [CountWidth-1:0] memUsed;

	TestOp opSequence [NumEntries];
	Entry stimulus [NumEntries];
	MemWord committed [$];
	MemWord pending [$];
	logic inTransaction;
	int cycleCount;

	ringBufferTop u_dut (
		.clk(clk),
		.rst(rst),
		.control(control),
		.pushRequest(pushRequest),
		.pushData(pushData),
		.pushDone(pushDone),
		.popRequest(popRequest),
		.popData(popData),
		.popDone(popDone),
		.memUsed(memUsed)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		state ^= state << 13;
		state ^= state >> 17;
		state ^= state << 5;
		return state;
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic checkWord(input MemWord actual, input MemWord expected);
		if (actual !== expected) begin
			failRun($sformatf("Mismatch popData: got 0x%h, expected 0x%h", actual, expected));
		end
	endtask

	task automatic checkCount(input logic [CountWidth-1:0] actual,
			input logic [CountWidth-1:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("Mismatch memUsed: got 0x%h, expected 0x%h", actual, expected));
		end
	endtask

	// Reference ring holds at most RingDepth-1 words and drops the oldest
	function automatic void modelPush(input MemWord word);
		if (inTransaction) begin
			pending.push_back(word);
		end else begin
			committed.push_back(word);
		end
		if (committed.size() + pending.size() > RingDepth - 1) begin
			if (committed.size() != 0) begin
				void'(committed.pop_front());
			end else begin
				void'(pending.pop_front());
			end
		end
	endfunction

	// A request raised here stays high until its own done pulse
	task automatic transfer(input logic doPush, input logic doPop, input MemWord word);
		logic pushSeen;
		logic popSeen;
		MemWord expected;
		pushSeen = !doPush;
		popSeen = !doPop;
		expected = '0;
		if (doPop) begin
			expected = committed.pop_front();
		end
		@(posedge clk);
		if (doPush) begin
			pushRequest <= 1'b1;
			pushData <= word;
		end
		if (doPop) begin
			popRequest <= 1'b1;
		end
		while (!(pushSeen && popSeen)) begin
			@(negedge clk);
			if (!pushSeen && pushDone) begin
				pushSeen = 1'b1;
			end
			if (!popSeen && popDone) begin
				popSeen = 1'b1;
				checkWord(popData, expected);
			end
			@(posedge clk);
			if (doPush && pushSeen) begin
				pushRequest <= 1'b0;
			end
			if (doPop && popSeen) begin
				popRequest <= 1'b0;
			end
		end
		if (doPush) begin
			modelPush(word);
		end
	endtask

	task automatic applyControl(input RingControl strobe);
		@(posedge clk);
		control <= strobe;
		@(posedge clk);
		control <= '0;
	endtask

	// Pop stays requested afterwards and completes in a later pop entry
	task automatic popOnEmpty();
		@(posedge clk);
		popRequest <= 1'b1;
		repeat (EmptyWait) begin
			@(negedge clk);
			if (popDone) begin
				failRun("popDone pulsed while the ring held no committed word");
			end
		end
	endtask

	task automatic applyEntry(input Entry entry);
		case (entry.op)
			OpPush: transfer(1'b1, 1'b0, entry.data);
			OpPop: transfer(1'b0, 1'b1, entry.data);
			OpPushPop: transfer(1'b1, 1'b1, entry.data);
			OpPopEmpty: popOnEmpty();
			OpOpen: begin
				applyControl('{open: 1'b1, commit: 1'b0, rollback: 1'b0});
				inTransaction = 1'b1;
			end
			OpCommit: begin
				applyControl('{open: 1'b0, commit: 1'b1, rollback: 1'b0});
				while (pending.size() != 0) begin
					committed.push_back(pending.pop_front());
				end
				inTransaction = 1'b0;
			end
			OpRollback: begin
				applyControl('{open: 1'b0, commit: 1'b0, rollback: 1'b1});
				pending.delete();
				inTransaction = 1'b0;
			end
			default: begin
				@(negedge clk);
				checkCount(memUsed, CountWidth'(committed.size()));
			end
		endcase
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		failRun($sformatf("Timeout: the run did not finish within %0d cycles", CycleLimit));
	end

	initial begin
		logic [31:0] seed;
		rst = 1'b1;
		control = '0;
		pushRequest = 1'b0;
		pushData = '0;
		popRequest = 1'b0;
		inTransaction = 1'b0;
		opSequence = '{
			// FIFO order outside a transaction
			OpPush, OpPush, OpPush, OpCheckUsed, OpPop, OpPop, OpPop, OpCheckUsed,
			// Commit makes pending words visible
			OpOpen, OpPush, OpPush, OpCheckUsed, OpCommit, OpCheckUsed, OpPop, OpPop,
			// Rolled back words never show up
			OpPush, OpOpen, OpPush, OpPush, OpRollback, OpCheckUsed, OpPush, OpPop, OpPop,
			OpCheckUsed,
			// Overflow drops the oldest
			OpPush, OpPush, OpPush, OpPush, OpPush, OpPush, OpPush, OpPush, OpPush,
			OpCheckUsed, OpPop, OpPop, OpPop, OpPop, OpPop, OpPop, OpPop, OpCheckUsed,
			// Pop waits on an empty ring
			OpOpen, OpPopEmpty, OpPush, OpCommit, OpPop, OpCheckUsed,
			// Writer and reader contend for memory
			OpPush, OpPush, OpPushPop, OpPushPop, OpPop, OpPop, OpCheckUsed
		};
		seed = 32'd3609;
		for (int i = 0; i < NumEntries; i++) begin
			seed = xorshift(seed);
			stimulus[i] = '{op: opSequence[i], data: seed[WordWidth-1:0]};
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < NumEntries; i++) begin
			applyEntry(stimulus[i]);
		end
		@(negedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

/* ringBufferTop.sv */
`timescale 1ns/1ps

module ringBufferTop (
	input logic clk,
	input logic rst,
	input ringPkg::RingControl control,
	input logic pushRequest,
	input ringPkg::MemWord pushData,
	output logic pushDone,
	input logic popRequest,
	output ringPkg::MemWord popData,
	output logic popDone,
	output logic [ringPkg::CountWidth-1:0] memUsed
);
	import ringPkg::*;

	ClientBus writeBus;
	ClientBus readBus;
	logic writeDone;
	logic readDone;
	logic writerGrantRequest;
	logic readerGrantRequest;
	logic [1:0] grants;
	MemRequest writerMem;
	MemRequest readerMem;
	MemRequest memRequest;
	MemResponse memResponse;

	ringBuffer u_ring (
		.clk(clk),
		.rst(rst),
		.control(control),
		.pushRequest(pushRequest),
		.pushData(pushData),
		.pushDone(pushDone),
		.popRequest(popRequest),
		.popDone(popDone),
		.memUsed(memUsed),
		.writeBus(writeBus),
		.writeDone(writeDone),
		.readBus(readBus),
		.readDone(readDone)
	);

	memoryWriter u_writer (
		.clk(clk),
		.rst(rst),
		.clientBus(writeBus),
		.done(writeDone),
		.grantRequest(writerGrantRequest),
		.grant(grants[0]),
		.memResponse(memResponse),
		.memRequest(writerMem)
	);

	memoryReader u_reader (
		.clk(clk),
		.rst(rst),
		.clientBus(readBus),
		.done(readDone),
		.grantRequest(readerGrantRequest),
		.grant(grants[1]),
		.memResponse(memResponse),
		.memRequest(readerMem),
		.rdWord(popData)
	);

	// Writer is client 0
	memoryArbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.requests({readerGrantRequest, writerGrantRequest}),
		.grants(grants),
		.writerMem(writerMem),
		.readerMem(readerMem),
		.memRequest(memRequest)
	);

	sharedMemory u_memory (
		.clk(clk),
		.rst(rst),
		.memRequest(memRequest),
		.memResponse(memResponse)
	);

endmodule

/* ringPkg.sv */
package ringPkg;

	localparam int WordWidth = 16;
	localparam int AddrWidth = 3;
	localparam int RingDepth = 8;
	localparam int MemLatency = 2;
	localparam int CountWidth = 4;

	typedef logic [WordWidth-1:0] MemWord;
	typedef logic [AddrWidth-1:0] MemAddr;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_ACTION,
		PRE_ACTION,
		ACTION,
		POST_ACTION
	} ClientState;

	// Client to arbiter, arbiter to memory
	typedef struct packed {
		logic writeEnable;
		logic readEnable;
		MemAddr addr;
		MemWord data;
	} MemRequest;

	typedef struct packed {
		logic busy;
		MemWord rdData;
	} MemResponse;

	// Ring to client
	typedef struct packed {
		logic request;
		MemAddr addr;
		MemWord data;
	} ClientBus;

	// Single-cycle strobes, never combined
	typedef struct packed {
		logic open;
		logic commit;
		logic rollback;
	} RingControl;

endpackage

/* run.sh */
#!/bin/sh
# Compile and run the ring buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module ringBufferTb \
	-Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^Testbench passed$"; then
	exit 0
fi
exit 1

/* sharedMemory.sv */
`timescale 1ns/1ps

module sharedMemory (
	input logic clk,
	input logic rst,
	input ringPkg::MemRequest memRequest,
	output ringPkg::MemResponse memResponse
);
	import ringPkg::*;

	typedef logic [$clog2(MemLatency + 1)-1:0] Countdown;

	MemWord mem [RingDepth];
	Countdown countdown;
	logic readPending;
	logic accept;
	MemAddr readAddr;
	MemWord readWord;

	// New access only while idle
	assign accept = (memRequest.writeEnable | memRequest.readEnable) && countdown == '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			countdown <= '0;
			readPending <= 1'b0;
		end else if (accept) begin
			countdown <= Countdown'(MemLatency);
			readPending <= memRequest.readEnable;
		end else if (countdown != '0) begin
			countdown <= countdown - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		// Write lands at the start of the access
		if (accept && memRequest.writeEnable) begin
			mem[memRequest.addr] <= memRequest.data;
		end
		if (accept) begin
			readAddr <= memRequest.addr;
		end
		// Read word appears as busy falls
		if (countdown == Countdown'(1) && readPending) begin
			readWord <= mem[readAddr];
		end
	end

	assign memResponse = '{busy: countdown != '0, rdData: readWord};

endmodule
